// File: hw/fetch_pkg.sv
//////////////////////////////
// shared constants and types for the two-wide fetch front end
// referenced by scoped name from the interface and every RTL module
//////////////////////////////

`default_nettype none

package fetch_pkg;

  ////////////////////////////// fetch geometry
  localparam int fetch_width = 2;   // slots per fetch, increment rule assumes two
  localparam int addr_width  = 64;  // pc width
  localparam int inst_width  = 32;  // one instruction word
  localparam int dword_width = fetch_width * inst_width;  // one memory row

  ////////////////////////////// instruction memory
  localparam int imem_depth       = 256;               // 64-bit rows
  localparam int imem_index_width = $clog2(imem_depth);
  localparam int imem_index_lsb   = 3;                 // row index starts at pc bit 3

  ////////////////////////////// fetch queue
  localparam int queue_depth       = 8;
  localparam int queue_ptr_width   = $clog2(queue_depth);
  localparam int queue_count_width = $clog2(queue_depth + 1);  // must hold 0..depth

  typedef logic [addr_width-1:0]        addr_t;
  typedef logic [inst_width-1:0]        inst_t;
  typedef logic [dword_width-1:0]       dword_t;
  typedef logic [queue_ptr_width-1:0]   ptr_t;
  typedef logic [queue_count_width-1:0] count_t;

  // occupancy of the fetch queue
  typedef enum logic [1:0]
  {
    empty   = 2'd0,
    partial = 2'd1,
    full    = 2'd2
  } queue_state_t;

endpackage

`default_nettype wire

// File: hw/imem_if.sv
//////////////////////////////
// fetch stage to instruction memory link
// rdata and valid follow addr combinationally in the same cycle
// busy is high while the load port writes a row
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

interface imem_if;

  fetch_pkg::addr_t  addr;   // doubleword aligned fetch address
  fetch_pkg::dword_t rdata;  // both instruction words of the row
  logic              valid;  // rdata good this cycle
  logic              busy;   // load in progress

  modport fetch
  (
    output addr,
    input  rdata, valid, busy
  );

  modport memory
  (
    input  addr,
    output rdata, valid, busy
  );

endinterface

`default_nettype wire

// File: hw/imem.sv
//////////////////////////////
// 64-bit wide instruction memory
// combinational read through the imem_if memory side,
// synchronous row writes from the top level load port
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module imem
(
  input  wire logic             clock,
  input  wire logic             reset,
  imem_if.memory                mem,
  input  wire logic             load_en,    // one row per strobe
  input  wire fetch_pkg::addr_t load_addr,  // byte address of the row
  input  wire fetch_pkg::dword_t load_data
);

  fetch_pkg::dword_t rows [fetch_pkg::imem_depth];  // program storage, no reset

  logic [fetch_pkg::imem_index_width-1:0] rd_index;
  logic [fetch_pkg::imem_index_width-1:0] wr_index;

  assign rd_index = mem.addr[fetch_pkg::imem_index_lsb +: fetch_pkg::imem_index_width];
  assign wr_index = load_addr[fetch_pkg::imem_index_lsb +: fetch_pkg::imem_index_width];

  ////////////////////////////// read side
  assign mem.rdata = rows[rd_index];  // no latency
  assign mem.valid = !load_en;        // data held back while a row changes
  assign mem.busy  = load_en;

  ////////////////////////////// load side
  always_ff @(posedge clock)
  begin
    if (load_en)
      rows[wr_index] <= load_data;
  end

  // fetch only ever asks for whole rows
  addr_aligned: assert property (@(posedge clock) disable iff (reset)
    mem.addr[fetch_pkg::imem_index_lsb-1:0] == '0)
    else $error("imem: fetch address %h not 8-byte aligned", mem.addr);

endmodule

`default_nettype wire

// File: hw/fetch_stage.sv
//////////////////////////////
// fetch stage: pc register, next pc choice and slot split
// one row per cycle gives up to two instructions, slot 0 is the
// low word and is skipped when the pc sits on the upper word
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module fetch_stage
(
  input  wire logic             clock,
  input  wire logic             reset,
  imem_if.fetch                 mem,
  input  wire logic             room,             // queue can take two more
  input  wire logic             redirect,         // taken branch strobe
  input  wire fetch_pkg::addr_t redirect_target,
  output logic [fetch_pkg::fetch_width-1:0] slot_valid,
  output fetch_pkg::addr_t [fetch_pkg::fetch_width-1:0] slot_pc,
  output fetch_pkg::inst_t [fetch_pkg::fetch_width-1:0] slot_inst
);

  fetch_pkg::addr_t pc;         // address being fetched now
  fetch_pkg::addr_t pc_plus;    // sequential successor
  fetch_pkg::addr_t next_pc;
  fetch_pkg::addr_t row_base;   // pc with the word offset dropped
  logic             advance;    // row accepted by the queue
  logic             pc_enable;

  assign row_base = {pc[fetch_pkg::addr_width-1:3], 3'b000};
  assign mem.addr = row_base;

  ////////////////////////////// next pc
  // upper word only has one slot left in the row
  assign pc_plus = pc[2] ? pc + fetch_pkg::addr_t'(4)
                         : pc + fetch_pkg::addr_t'(fetch_pkg::fetch_width * 4);

  assign next_pc   = redirect ? redirect_target : pc_plus;
  assign advance   = mem.valid && room;
  assign pc_enable = advance || redirect;  // a redirect must never be dropped by a stall

  always_ff @(posedge clock)
  begin
    if (reset)
      pc <= '0;
    else if (pc_enable)
      pc <= next_pc;
  end

  ////////////////////////////// slot split
  assign slot_inst[0] = mem.rdata[fetch_pkg::inst_width-1:0];  // low word
  assign slot_inst[1] = mem.rdata[fetch_pkg::dword_width-1:fetch_pkg::inst_width];

  assign slot_pc[0] = pc;
  assign slot_pc[1] = row_base + fetch_pkg::addr_t'(4);

  // low slot is behind the pc when bit 2 is set
  assign slot_valid[0] = advance && !pc[2];
  assign slot_valid[1] = advance;

  // redirect targets arrive from outside, so check alignment over time
  pc_word_aligned: assert property (@(posedge clock) disable iff (reset)
    pc[1:0] == 2'b00)
    else $error("fetch_stage: pc %h not word aligned", pc);

  // a load holds the pc unless a redirect moves it
  pc_holds_while_busy: assert property (@(posedge clock) disable iff (reset)
    mem.busy && !redirect |=> $stable(pc))
    else $error("fetch_stage: pc moved during a memory load");

endmodule

`default_nettype wire

// File: hw/fetch_queue.sv
//////////////////////////////
// fetch queue between the fetch stage and decode
// takes up to two instructions per cycle in slot order and
// hands one per cycle to registered deq outputs
// flush drops everything, including the output register
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module fetch_queue
(
  input  wire logic clock,
  input  wire logic reset,
  input  wire logic flush,                                     // same as redirect
  input  wire logic [fetch_pkg::fetch_width-1:0] slot_valid,
  input  wire fetch_pkg::addr_t [fetch_pkg::fetch_width-1:0] slot_pc,
  input  wire fetch_pkg::inst_t [fetch_pkg::fetch_width-1:0] slot_inst,
  output logic             room,      // at least two entries free
  output logic             deq_valid,
  output fetch_pkg::addr_t deq_pc,
  output fetch_pkg::inst_t deq_inst
);

  fetch_pkg::addr_t entry_pc   [fetch_pkg::queue_depth];
  fetch_pkg::inst_t entry_inst [fetch_pkg::queue_depth];

  fetch_pkg::ptr_t         head;      // oldest entry
  fetch_pkg::ptr_t         tail;      // next free entry
  fetch_pkg::count_t       count;
  fetch_pkg::count_t       wr_count;  // slots written this cycle
  fetch_pkg::ptr_t         slot1_ptr; // slot 1 lands after slot 0 if that one is valid
  fetch_pkg::queue_state_t state;
  logic                    push;
  logic                    pop;

  ////////////////////////////// occupancy
  always_comb
  begin
    if (count == '0)
      state = fetch_pkg::empty;
    else if (count == fetch_pkg::count_t'(fetch_pkg::queue_depth))
      state = fetch_pkg::full;
    else
      state = fetch_pkg::partial;
  end

  assign room = (fetch_pkg::count_t'(fetch_pkg::queue_depth) - count)
                >= fetch_pkg::count_t'(fetch_pkg::fetch_width);

  assign wr_count  = fetch_pkg::count_t'(slot_valid[0]) + fetch_pkg::count_t'(slot_valid[1]);
  assign slot1_ptr = tail + fetch_pkg::ptr_t'(slot_valid[0]);
  assign push      = |slot_valid && !flush;  // stale slots die with the flush
  assign pop       = (state != fetch_pkg::empty) && !flush;

  ////////////////////////////// storage, no reset
  always_ff @(posedge clock)
  begin
    if (push && slot_valid[0])
    begin
      entry_pc[tail]   <= slot_pc[0];
      entry_inst[tail] <= slot_inst[0];
    end
    if (push && slot_valid[1])
    begin
      entry_pc[slot1_ptr]   <= slot_pc[1];
      entry_inst[slot1_ptr] <= slot_inst[1];
    end
    if (pop)
    begin
      deq_pc   <= entry_pc[head];    // payload only, qualified by deq_valid
      deq_inst <= entry_inst[head];
    end
  end

  ////////////////////////////// pointers and output strobe
  always_ff @(posedge clock)
  begin
    if (reset || flush)
    begin
      head      <= '0;
      tail      <= '0;
      count     <= '0;
      deq_valid <= 1'b0;  // nothing older than the redirect leaves
    end
    else
    begin
      if (push)
        tail <= tail + fetch_pkg::ptr_t'(wr_count);
      if (pop)
        head <= head + fetch_pkg::ptr_t'(1);
      count     <= count + (push ? wr_count : '0) - fetch_pkg::count_t'(pop);
      deq_valid <= pop;
    end
  end

  // room gating in the fetch stage keeps writes inside the buffer
  no_overflow: assert property (@(posedge clock) disable iff (reset)
    push |-> (count + wr_count) <= fetch_pkg::count_t'(fetch_pkg::queue_depth))
    else $error("fetch_queue: write of %0d with %0d entries held", wr_count, count);

  // head only meets tail on a pop when every entry is held
  no_pop_empty: assert property (@(posedge clock) disable iff (reset)
    pop |-> (head != tail) || (state == fetch_pkg::full))
    else $error("fetch_queue: deq from empty queue");

endmodule

`default_nettype wire

// File: hw/fetch_front_end.sv
//////////////////////////////
// fetch front end top level
// memory, fetch stage and fetch queue behind plain ports
// program rows come in on the load port, decode reads the deq strobe
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module fetch_front_end
(
  input  wire logic              clock,
  input  wire logic              reset,
  input  wire logic              redirect,         // taken branch strobe
  input  wire fetch_pkg::addr_t  redirect_target,
  input  wire logic              load_en,          // one row per strobe
  input  wire fetch_pkg::addr_t  load_addr,
  input  wire fetch_pkg::dword_t load_data,
  output logic                   deq_valid,        // one instruction per strobe
  output fetch_pkg::addr_t       deq_pc,
  output fetch_pkg::inst_t       deq_inst
);

  logic [fetch_pkg::fetch_width-1:0]                slot_valid;
  fetch_pkg::addr_t [fetch_pkg::fetch_width-1:0]    slot_pc;
  fetch_pkg::inst_t [fetch_pkg::fetch_width-1:0]    slot_inst;
  logic                                             room;  // get next row

  imem_if i_imem_if ();

  imem i_imem
  (
    .clock     (clock),
    .reset     (reset),
    .mem       (i_imem_if.memory),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data)
  );

  fetch_stage i_fetch_stage
  (
    .clock           (clock),
    .reset           (reset),
    .mem             (i_imem_if.fetch),
    .room            (room),
    .redirect        (redirect),
    .redirect_target (redirect_target),
    .slot_valid      (slot_valid),
    .slot_pc         (slot_pc),
    .slot_inst       (slot_inst)
  );

  fetch_queue i_fetch_queue
  (
    .clock      (clock),
    .reset      (reset),
    .flush      (redirect),  // stale rows go with the redirect
    .slot_valid (slot_valid),
    .slot_pc    (slot_pc),
    .slot_inst  (slot_inst),
    .room       (room),
    .deq_valid  (deq_valid),
    .deq_pc     (deq_pc),
    .deq_inst   (deq_inst)
  );

endmodule

`default_nettype wire

// File: test/tb_clock.sv
//////////////////////////////
// testbench clock and power-on reset
// 100 ns period, reset held for the first 10 rising edges
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_clock
(
  output logic clock,
  output logic reset
);

  initial
  begin
    clock = 1'b0;
    forever
      #50 clock = ~clock;  // half period
  end

  initial
  begin
    reset = 1'b1;
    repeat (10)
      @(posedge clock);
    reset <= 1'b0;  // let go on a rising edge like the rest of the stimulus
  end

endmodule

`default_nettype wire

// File: test/tb_fetch.sv
//////////////////////////////
// testbench for the fetch front end
// runs load, reset, redirect and expect commands from the test file,
// mirrors the memory rows and checks every dequeued instruction
// against the next sequential pc
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_fetch;

  logic              clock;
  logic              start_reset;    // power-on reset from the clock module
  logic              test_reset;     // reset command from the file
  logic              reset;
  logic              redirect;
  fetch_pkg::addr_t  redirect_target;
  logic              load_en;
  fetch_pkg::addr_t  load_addr;
  fetch_pkg::dword_t load_data;
  logic              deq_valid;
  fetch_pkg::addr_t  deq_pc;
  fetch_pkg::inst_t  deq_inst;

  fetch_pkg::dword_t model_rows [fetch_pkg::imem_depth];  // mirror of the memory
  fetch_pkg::addr_t  expected_pc = '0;   // pc due next at decode
  fetch_pkg::inst_t  expected_inst;
  int                checked_count = 0;  // instructions compared so far
  int                fd;

  assign reset = start_reset || test_reset;

  tb_clock i_tb_clock (.clock(clock), .reset(start_reset));

  fetch_front_end i_dut
  (
    .clock           (clock),
    .reset           (reset),
    .redirect        (redirect),
    .redirect_target (redirect_target),
    .load_en         (load_en),
    .load_addr       (load_addr),
    .load_data       (load_data),
    .deq_valid       (deq_valid),
    .deq_pc          (deq_pc),
    .deq_inst        (deq_inst)
  );

  ////////////////////////////// helpers
  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // background row content, the whole row index goes into the seed
  function automatic fetch_pkg::dword_t fill_row(input int row);
    logic [31:0] seed;
    seed = 32'hf1fe_33de;
    return {lcg_next(seed ^ {row[30:0], 1'b1}), lcg_next(seed ^ {row[30:0], 1'b0})};
  endfunction

  task automatic report_value(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
    $display("[ERROR] time %0t: %s is %h, expected %h", $time, name, actual, expected);
    $display("*** FAILED ***");
    $fatal(1, "stopped at the first mismatch");
  endtask

  task automatic report_failure(input string what);
    $display("time %0t: %s", $time, what);
    $display("*** FAILED ***");
    $fatal(1, "stopped at the first failure");
  endtask

  // strobes last one cycle unless the caller sets them again
  task automatic next_edge();
    @(posedge clock);
    load_en    <= 1'b0;
    redirect   <= 1'b0;
    test_reset <= 1'b0;
  endtask

  task automatic load_row(input logic [31:0] row, input fetch_pkg::dword_t data);
    next_edge();
    load_en   <= 1'b1;
    load_addr <= fetch_pkg::addr_t'({row, 3'b000});  // byte address of the row
    load_data <= data;
    model_rows[row[7:0]] = data;
  endtask

  // waits until n more instructions went through the checker
  task automatic wait_for_items(input int n);
    int goal;
    int cycles;
    goal   = checked_count + n;
    cycles = 0;
    next_edge();
    while (checked_count < goal)
    begin
      @(posedge clock);
      cycles++;
      if (cycles > n * 4 + 50)
        report_failure("dequeued stream stopped before the expected count");
    end
  endtask

  ////////////////////////////// command file
  task automatic run_command(input string cmd);
    logic [31:0]       row;
    fetch_pkg::dword_t data;
    fetch_pkg::addr_t  target;
    int                count;
    int                status;
    logic [8*200-1:0]  rest;
    if (cmd == "#")
      status = $fgets(rest, fd);  // skip the comment text
    else if (cmd == "load")
    begin
      status = $fscanf(fd, "%h %h", row, data);
      if (status != 2)
        report_failure("load command without row and data");
      else
        load_row(row, data);
    end
    else if (cmd == "redirect")
    begin
      status = $fscanf(fd, "%h", target);
      if (status != 1)
        report_failure("redirect command without a target");
      else
      begin
        next_edge();
        redirect        <= 1'b1;
        redirect_target <= target;
      end
    end
    else if (cmd == "reset")
    begin
      next_edge();
      test_reset <= 1'b1;
      next_edge();
      test_reset <= 1'b1;  // two cycles of reset
    end
    else if (cmd == "expect")
    begin
      status = $fscanf(fd, "%d", count);
      if (status != 1)
        report_failure("expect command without a count");
      else
        wait_for_items(count);
    end
    else
      report_failure({"unknown command in the test file: ", cmd});
  endtask

  task automatic run_test_file();
    string cmd;
    int    status;
    status = $fscanf(fd, "%s", cmd);
    while (status == 1)
    begin
      run_command(cmd);
      status = $fscanf(fd, "%s", cmd);
    end
    $fclose(fd);
  endtask

  ////////////////////////////// output checker
  // deq outputs settle after the rising edge, sampled on the falling one
  always @(negedge clock)
  begin
    if (reset)
      expected_pc = '0;  // stream restarts at pc 0
    else if (deq_valid)
    begin
      expected_inst = expected_pc[2] ? model_rows[expected_pc[10:3]][63:32]
                                     : model_rows[expected_pc[10:3]][31:0];
      assert (deq_pc == expected_pc)
        else report_value("deq_pc", deq_pc, expected_pc);
      assert (deq_inst == expected_inst)
        else report_value("deq_inst", 64'(deq_inst), 64'(expected_inst));
      expected_pc   = expected_pc + 64'd4;
      checked_count = checked_count + 1;
    end
    if (redirect)
      expected_pc = redirect_target;  // older entries die at the next edge
  end

  ////////////////////////////// main sequence
  initial
  begin
    redirect        = 1'b0;
    redirect_target = '0;
    load_en         = 1'b0;
    load_addr       = '0;
    load_data       = '0;
    test_reset      = 1'b0;

    // every row is written before the test file starts
    // fetch sits on the busy memory until then
    for (int row = 0; row < fetch_pkg::imem_depth; row++)
      load_row(row, fill_row(row));

    fd = $fopen("test/fetch_tests.txt", "r");
    if (fd == 0)
      report_failure("cannot open test/fetch_tests.txt");
    else
    begin
      run_test_file();
      next_edge();
      if (checked_count > 0)
      begin
        $display("*** PASSED ***");
        $finish;
      end
      else
        report_failure("the test file checked no instruction");
    end
  end

endmodule

`default_nettype wire

// File: test/fetch_tests.txt
# commands: load <row hex> <row data hex, high word at pc+4> | reset
#           redirect <target pc hex> | expect <instruction count>
# sequential stream from reset
expect 40
# rows well ahead of fetch, loaded mid-run
load 28 c0de0051c0de0050
load 29 c0de0053c0de0052
load 2a c0de0055c0de0054
expect 80
# long run with the queue saturated
expect 200
# flush while the queue is full
redirect 0000000000000100
expect 12
# target on the upper word
redirect 000000000000024c
expect 10
# back-to-back redirects, second one wins
redirect 0000000000000400
redirect 000000000000051c
expect 16
# new first rows, seen after reset
load 00 1111000211110001
load 01 1111000411110003
reset
expect 24
# last row of the index range, wraps to row 0
redirect 0000000010000ff8
expect 12

// File: sim.f
hw/fetch_pkg.sv
hw/imem_if.sv
hw/imem.sv
hw/fetch_stage.sv
hw/fetch_queue.sv
hw/fetch_front_end.sv
test/tb_clock.sv
test/tb_fetch.sv

// File: Makefile
# verilator build and run of the fetch front end testbench

run: obj_dir/Vtb_fetch
	./obj_dir/Vtb_fetch

# rebuilt only when a source or the file list changes
obj_dir/Vtb_fetch: sim.f $(wildcard hw/*.sv test/*.sv)
	verilator --binary --timing --assert --top-module tb_fetch -f sim.f

clean:
	rm -rf obj_dir

.PHONY: run clean
